/* Bender.yml */
package:
  name: imuldiv

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/imuldiv_msg_pkg.sv
      - verilog/imuldiv_ctrl_pkg.sv
      - verilog/imuldiv_div_iterative.sv
      - verilog/imuldiv_mul_iterative.sv
      - verilog/imuldiv_issue_arbiter.sv
      - verilog/imuldiv_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/imuldiv_chk.sv
      - tb/imuldiv_tb.sv

/* tb/imuldiv_chk.sv */
/*
 * Handshake and stability properties of the multiply/divide unit's ports.
 * Bound to imuldiv_top; failures raise $error and bump fail_count.
 */
`timescale 1ns/100ps

module imuldiv_chk (
  input logic                       clk,
  input logic                       reset,
  input logic                       req_val,
  input logic                       req_rdy,
  input logic                       resp_val,
  input logic                       resp_rdy,
  input imuldiv_msg_pkg::resp_msg_t resp_msg
);

  // read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // a reset cycle leaves both engines idle, nothing offered
  resp_low_in_reset: assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high after a reset cycle");
      fail_count++;
    end

  // a stalled response must not change under the consumer
  resp_stable_when_stalled: assert property (@(posedge clk) disable iff (reset)
      (resp_val && !resp_rdy) |=> $stable(resp_msg))
    else begin
      $error("resp_msg changed while stalled");
      fail_count++;
    end

  // the selected engine leaves IDLE on the accepting edge
  req_rdy_drops_after_accept: assert property (@(posedge clk) disable iff (reset)
      (req_val && req_rdy) |=> !req_rdy)
    else begin
      $error("req_rdy still high after an accepted request");
      fail_count++;
    end

endmodule

bind imuldiv_top imuldiv_chk u_chk (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .resp_msg (resp_msg)
);

/* tb/imuldiv_tb.sv */
/*
 * Testbench for imuldiv_top: random and edge-case MUL/DIV/DIVU requests,
 * overlap of both engines, back-pressure and busy-engine blocking.
 */
`timescale 1ns/100ps
`include "imuldiv_macros.svh"

module imuldiv_tb;

  localparam int xlen       = `IMULDIV_XLEN;
  localparam int tag_w      = `IMULDIV_TAG_W;
  localparam int tag_count  = 1 << tag_w;
  localparam int wait_limit = 100;

  logic                       clk;
  logic                       reset;
  logic                       req_val;
  imuldiv_msg_pkg::req_msg_t  req_msg;
  logic                       req_rdy;
  logic                       resp_val;
  imuldiv_msg_pkg::resp_msg_t resp_msg;
  logic                       resp_rdy;

  // scoreboard, one slot per tag
  logic [2*xlen-1:0] exp_result [tag_count];
  bit                exp_valid  [tag_count];
  logic [tag_w-1:0]  next_tag;

  integer seed = 32'h5854_6417;
  int     checks;
  int     errors;
  int     tests;
  int     errors_at_start;
  bit     timed_out;

  imuldiv_top uut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_msg  (req_msg),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_msg (resp_msg),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //------------------------------------------------------------
  // reference model
  //------------------------------------------------------------

  // divides pack remainder high and quotient low
  function automatic logic [2*xlen-1:0] expected_result(input logic [1:0] fn,
      input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    longint      sa;
    longint      sb;
    longint      q;
    longint      r;
    logic [63:0] uq;
    logic [63:0] ur;
    sa = $signed(a);
    sb = $signed(b);
    if (fn == `IMULDIV_FN_MUL) begin
      return sa * sb;
    end else if (fn == `IMULDIV_FN_DIV) begin
      // 64-bit math, so min / -1 wraps back to min in the low word
      q = sa / sb;
      r = sa % sb;
      return {r[xlen-1:0], q[xlen-1:0]};
    end else if (b == '0) begin
      return {a, {xlen{1'b1}}};
    end
    uq = {32'b0, a} / {32'b0, b};
    ur = {32'b0, a} % {32'b0, b};
    return {ur[xlen-1:0], uq[xlen-1:0]};
  endfunction

  //------------------------------------------------------------
  // checks and reporting
  //------------------------------------------------------------

  task automatic check_equal(input string what, input logic [63:0] got,
      input logic [63:0] exp);
    if (timed_out) return;
    checks++;
    assert (got === exp) else begin
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    if (timed_out) return;
    checks++;
    assert (cond === 1'b1) else begin
      $display("ERROR %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
    timed_out = 1'b1;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  //------------------------------------------------------------
  // handshakes, all entered and left 1 ns after a rising edge
  //------------------------------------------------------------

  task automatic drive_req(input logic [1:0] fn, input logic [xlen-1:0] a,
      input logic [xlen-1:0] b, output logic [tag_w-1:0] tag);
    tag = next_tag;
    if (timed_out) return;
    next_tag = next_tag + 1'b1;
    exp_result[tag] = expected_result(fn, a, b);
    exp_valid[tag]  = 1'b1;
    req_msg.fn  = fn;
    req_msg.tag = tag;
    req_msg.a   = a;
    req_msg.b   = b;
    req_val     = 1'b1;
  endtask

  task automatic wait_accept();
    int cycles;
    bit accepted;
    if (timed_out) return;
    cycles   = 0;
    accepted = 1'b0;
    while (!accepted && cycles < wait_limit) begin
      #1;
      if (req_rdy) begin
        accepted = 1'b1;
      end else begin
        cycles++;
        @(posedge clk);
        #1;
      end
    end
    if (!accepted) begin
      report_timeout("request acceptance");
      req_val = 1'b0;
      return;
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
    // fn held one more cycle so the engine is seen busy
    @(posedge clk);
    #1;
  endtask

  task automatic send_req(input logic [1:0] fn, input logic [xlen-1:0] a,
      input logic [xlen-1:0] b, output logic [tag_w-1:0] tag);
    drive_req(fn, a, b, tag);
    wait_accept();
  endtask

  // caller keeps resp_rdy high, the transfer is on the next edge
  task automatic recv_resp(output logic [tag_w-1:0] tag);
    int cycles;
    bit seen;
    tag = '0;
    if (timed_out) return;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < wait_limit) begin
      #1;
      if (resp_val) begin
        seen = 1'b1;
      end else begin
        cycles++;
        @(posedge clk);
        #1;
      end
    end
    if (!seen) begin
      report_timeout("response");
      return;
    end
    tag = resp_msg.tag;
    check_true($sformatf("tag %0d has an outstanding request", tag), exp_valid[tag]);
    check_equal($sformatf("result for tag %0d", tag), resp_msg.result, exp_result[tag]);
    exp_valid[tag] = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_both_done();
    int cycles;
    bit done;
    if (timed_out) return;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < wait_limit) begin
      #1;
      if (uut.div_resp_val && uut.mul_resp_val) begin
        done = 1'b1;
      end else begin
        cycles++;
        @(posedge clk);
        #1;
      end
    end
    if (!done) report_timeout("both engines finishing");
  endtask

  task automatic run_one(input logic [1:0] fn, input logic [xlen-1:0] a,
      input logic [xlen-1:0] b);
    logic [tag_w-1:0] tag;
    logic [tag_w-1:0] got;
    send_req(fn, a, b, tag);
    recv_resp(got);
    check_equal("response tag", got, tag);
  endtask

  //------------------------------------------------------------
  // test sequence
  //------------------------------------------------------------

  initial begin
    logic [tag_w-1:0] t1;
    logic [tag_w-1:0] t2;
    logic [tag_w-1:0] g1;
    logic [tag_w-1:0] g2;
    logic [xlen-1:0]  a;
    logic [xlen-1:0]  b;
    logic [1:0]       fn;
    int               pick;
    int               cycles;
    int               held;
    reset           = 1'b1;
    req_val         = 1'b0;
    req_msg         = '0;
    resp_rdy        = 1'b0;
    next_tag        = '0;
    checks          = 0;
    errors          = 0;
    tests           = 0;
    errors_at_start = 0;
    timed_out       = 1'b0;
    foreach (exp_valid[i]) exp_valid[i] = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // 1: both engines idle, nothing offered
    #1;
    check_true("multiplier ready after reset", req_rdy);
    check_true("resp_val low after reset", !resp_val);
    @(posedge clk);
    #1;
    req_msg.fn = `IMULDIV_FN_DIV;
    #1;
    check_true("divider ready after reset", req_rdy);
    @(posedge clk);
    #1;
    finish_test("reset state");

    // 2: one at a time, divisors shifted down for larger quotients
    resp_rdy = 1'b1;
    for (int i = 0; i < 30; i++) begin
      pick = $unsigned($random(seed)) % 3;
      fn   = (pick == 0) ? `IMULDIV_FN_MUL :
             (pick == 1) ? `IMULDIV_FN_DIV : `IMULDIV_FN_DIVU;
      a    = $random(seed);
      b    = $random(seed);
      b    = $signed(b) >>> ($unsigned($random(seed)) % xlen);
      if (b == '0) b = 1;
      run_one(fn, a, b);
    end
    finish_test("random operations");

    // 3: zero divisor, overflow and every sign combination
    run_one(`IMULDIV_FN_DIVU, 32'h1234_5678, 32'h0);
    run_one(`IMULDIV_FN_DIVU, 32'hFFFF_FFFF, 32'h0);
    run_one(`IMULDIV_FN_DIVU, 32'hFFFF_FFFE, 32'd3);
    run_one(`IMULDIV_FN_DIV, 32'h8000_0000, 32'hFFFF_FFFF);
    run_one(`IMULDIV_FN_DIV, 32'sd100, 32'sd7);
    run_one(`IMULDIV_FN_DIV, -32'sd100, 32'sd7);
    run_one(`IMULDIV_FN_DIV, 32'sd100, -32'sd7);
    run_one(`IMULDIV_FN_DIV, -32'sd100, -32'sd7);
    run_one(`IMULDIV_FN_MUL, 32'sd1234, -32'sd56);
    run_one(`IMULDIV_FN_MUL, -32'sd1234, 32'sd56);
    run_one(`IMULDIV_FN_MUL, -32'sd1234, -32'sd56);
    run_one(`IMULDIV_FN_MUL, 32'h8000_0000, 32'h8000_0000);
    run_one(`IMULDIV_FN_MUL, 32'h8000_0000, 32'hFFFF_FFFF);
    finish_test("edge operands");

    // 4: multiplier accepted while the divider iterates
    send_req(`IMULDIV_FN_DIV, -32'sd987654, 32'sd321, t1);
    send_req(`IMULDIV_FN_MUL, 32'sd77777, -32'sd4321, t2);
    check_true("divider still busy when MUL accepted", !uut.div_req_rdy);
    recv_resp(g1);
    recv_resp(g2);
    check_true("both overlapped tags returned", !exp_valid[t1] && !exp_valid[t2]);
    finish_test("overlapped engines");

    // 5: hold both results, then drain one per cycle
    // multiplier finishes first and has to stay on the port while stalled
    resp_rdy = 1'b0;
    send_req(`IMULDIV_FN_MUL, 32'h0BAD_F00D, 32'hFFFF_0001, t1);
    send_req(`IMULDIV_FN_DIVU, 32'hDEAD_BEEF, 32'h0000_1234, t2);
    wait_both_done();
    resp_rdy = 1'b1;
    recv_resp(g1);
    recv_resp(g2);
    check_true("held responses come from different engines",
               (g1 == t1 && g2 == t2) || (g1 == t2 && g2 == t1));
    finish_test("back-pressure");

    // 6: second divide waits for the first to leave DONE
    resp_rdy = 1'b0;
    send_req(`IMULDIV_FN_DIV, 32'sd123456789, -32'sd1000, t1);
    drive_req(`IMULDIV_FN_DIVU, 32'h8765_4321, 32'h0000_00FF, t2);
    cycles = 0;
    held   = 0;
    while (!timed_out && held < 3 && cycles < wait_limit) begin
      #1;
      check_true("req_rdy low while divider busy", !req_rdy);
      if (resp_val) held++;
      cycles++;
      @(posedge clk);
      #1;
    end
    if (!timed_out && held < 3) report_timeout("divider finishing");
    resp_rdy = 1'b1;
    recv_resp(g1);
    check_equal("first divide drains first", g1, t1);
    wait_accept();
    recv_resp(g2);
    check_equal("blocked divide tag", g2, t2);
    finish_test("busy engine blocks");

    $display("tests %0d, checks %0d, check errors %0d, protocol errors %0d",
             tests, checks, errors, uut.u_chk.fail_count);
    if (errors == 0 && !timed_out && uut.u_chk.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verilog
verilog/imuldiv_msg_pkg.sv
verilog/imuldiv_ctrl_pkg.sv
verilog/imuldiv_div_iterative.sv
verilog/imuldiv_mul_iterative.sv
verilog/imuldiv_issue_arbiter.sv
verilog/imuldiv_top.sv
tb/imuldiv_chk.sv
tb/imuldiv_tb.sv

/* verilog/imuldiv_ctrl_pkg.sv */
/*
 * Control words, status bits and FSM states shared between each engine's
 * controller and its datapath.
 */
`include "imuldiv_macros.svh"

package imuldiv_ctrl_pkg;

  // iteration counter counts down from ITERS-1
  localparam int unsigned cntr_w = $clog2(`IMULDIV_ITERS);

  // both engines run the same three-state sequence
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } engine_state_t;

  //------------------------------------------------------------
  // divider
  //------------------------------------------------------------

  typedef struct packed {
    logic a_en;          // load or update remainder/quotient reg
    logic b_en;          // load divisor reg
    logic a_mux_sel;     // 0 = initial operand, 1 = iteration result
    logic sub_mux_sel;   // 1 = restore, quotient bit 0
    logic cntr_mux_sel;  // 0 = reload, 1 = decrement
    logic sign_en;       // capture operand signs
    logic is_signed;     // DIV, operands taken as magnitudes
    logic rem_sign_sel;  // apply remainder fix-up
    logic div_sign_sel;  // apply quotient fix-up
  } div_ctrl_t;

  typedef struct packed {
    logic sub_msb;
    logic counter_is_zero;
  } div_stat_t;

  //------------------------------------------------------------
  // multiplier
  //------------------------------------------------------------

  typedef struct packed {
    logic load;    // capture operand magnitudes and sign
    logic shift;   // one iteration
    logic add;     // accumulate the shifted multiplicand
    logic negate;  // apply the sign fix-up to the product
  } mul_ctrl_t;

  typedef struct packed {
    logic mplier_lsb;
    logic counter_is_zero;
  } mul_stat_t;

endpackage

/* verilog/imuldiv_div_iterative.sv */
/*
 * Iterative restoring divider for DIV and DIVU, one quotient bit per cycle.
 * Controller and datapath are split; the wrapper adds the tag and handshake.
 */
`timescale 1ns/100ps
`include "imuldiv_macros.svh"

module imuldiv_div_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  input  imuldiv_msg_pkg::req_msg_t req_msg,
  output logic                      req_rdy,
  output logic                      resp_val,
  output imuldiv_msg_pkg::resp_msg_t resp_msg,
  input  logic                      resp_rdy
);

  imuldiv_ctrl_pkg::div_ctrl_t ctrl;
  imuldiv_ctrl_pkg::div_stat_t stat;
  logic [2*`IMULDIV_XLEN-1:0]  result;
  logic [`IMULDIV_TAG_W-1:0]   tag_reg;

  // tag rides alongside the operation, captured on the accepting edge
  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      tag_reg <= req_msg.tag;
    end
  end

  assign resp_msg.tag    = tag_reg;
  assign resp_msg.result = result;

  imuldiv_div_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .fn       (req_msg.fn),
    .stat     (stat),
    .ctrl     (ctrl)
  );

  imuldiv_div_dpath u_dpath (
    .clk     (clk),
    .reset   (reset),
    .req_msg (req_msg),
    .ctrl    (ctrl),
    .stat    (stat),
    .result  (result)
  );

endmodule

//------------------------------------------------------------
// datapath
//------------------------------------------------------------

module imuldiv_div_dpath (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_msg_pkg::req_msg_t   req_msg,
  input  imuldiv_ctrl_pkg::div_ctrl_t ctrl,
  output imuldiv_ctrl_pkg::div_stat_t stat,
  output logic [2*`IMULDIV_XLEN-1:0]  result
);

  localparam int w = `IMULDIV_XLEN;

  logic [2*w:0]                         a_reg;
  logic [2*w:0]                         b_reg;
  logic [imuldiv_ctrl_pkg::cntr_w-1:0]  counter;
  logic                                 div_sign;
  logic                                 rem_sign;
  logic [w-1:0]                         a_in;
  logic [w-1:0]                         b_in;
  logic [2*w:0]                         a_shift;
  logic [2*w:0]                         diff;
  logic [2*w:0]                         a_next;
  logic [w-1:0]                         quo;
  logic [w-1:0]                         rem;

  // signed DIV works on magnitudes, DIVU passes operands through
  assign a_in = (ctrl.is_signed && req_msg.a[w-1]) ? (~req_msg.a + 1'b1) : req_msg.a;
  assign b_in = (ctrl.is_signed && req_msg.b[w-1]) ? (~req_msg.b + 1'b1) : req_msg.b;

  // shift, then trial subtract of the divisor sitting in the upper word
  assign a_shift = a_reg << 1;
  assign diff    = a_shift - b_reg;

  // negative difference means restore with quotient bit 0
  always_comb begin
    if (!ctrl.a_mux_sel) begin
      a_next = {{(w+1){1'b0}}, a_in};
    end else if (ctrl.sub_mux_sel) begin
      a_next = {a_shift[2*w:1], 1'b0};
    end else begin
      a_next = {diff[2*w:1], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      a_reg <= a_next;
    end
    if (ctrl.b_en) begin
      b_reg <= {1'b0, b_in, {w{1'b0}}};
    end
    // sign regs stay clear for DIVU so the fix-up never fires
    if (ctrl.sign_en) begin
      div_sign <= ctrl.is_signed & (req_msg.a[w-1] ^ req_msg.b[w-1]);
      rem_sign <= ctrl.is_signed & req_msg.a[w-1];
    end
  end

  // reload every cycle outside CALC, so accept always starts at ITERS-1
  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
    end else if (ctrl.cntr_mux_sel) begin
      counter <= counter - 1'b1;
    end else begin
      counter <= imuldiv_ctrl_pkg::cntr_w'(`IMULDIV_ITERS - 1);
    end
  end

  assign stat.sub_msb         = diff[2*w];
  assign stat.counter_is_zero = (counter == '0);

  // quotient takes the xor of signs, remainder follows the dividend
  assign quo = a_reg[w-1:0];
  assign rem = a_reg[2*w-1:w];
  assign result[w-1:0]   = (ctrl.div_sign_sel && div_sign) ? (~quo + 1'b1) : quo;
  assign result[2*w-1:w] = (ctrl.rem_sign_sel && rem_sign) ? (~rem + 1'b1) : rem;

endmodule

//------------------------------------------------------------
// controller
//------------------------------------------------------------

module imuldiv_div_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_val,
  output logic                        req_rdy,
  output logic                        resp_val,
  input  logic                        resp_rdy,
  input  logic [`IMULDIV_FN_W-1:0]    fn,
  input  imuldiv_ctrl_pkg::div_stat_t stat,
  output imuldiv_ctrl_pkg::div_ctrl_t ctrl
);

  imuldiv_ctrl_pkg::engine_state_t state;
  logic                            accept;

  assign accept = (state == imuldiv_ctrl_pkg::IDLE) && req_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_ctrl_pkg::IDLE;
    end else begin
      case (state)
        imuldiv_ctrl_pkg::IDLE: if (accept) state <= imuldiv_ctrl_pkg::CALC;
        imuldiv_ctrl_pkg::CALC: if (stat.counter_is_zero) state <= imuldiv_ctrl_pkg::DONE;
        imuldiv_ctrl_pkg::DONE: if (resp_rdy) state <= imuldiv_ctrl_pkg::IDLE;
        default: state <= imuldiv_ctrl_pkg::IDLE;
      endcase
    end
  end

  // enables and selects are pure functions of state and status
  always_comb begin
    ctrl           = '0;
    req_rdy        = 1'b0;
    resp_val       = 1'b0;
    ctrl.is_signed = (fn == `IMULDIV_FN_DIV);
    case (state)
      imuldiv_ctrl_pkg::IDLE: begin
        req_rdy      = 1'b1;
        ctrl.a_en    = accept;
        ctrl.b_en    = accept;
        ctrl.sign_en = accept;
      end
      imuldiv_ctrl_pkg::CALC: begin
        ctrl.a_en         = 1'b1;
        ctrl.a_mux_sel    = 1'b1;
        ctrl.sub_mux_sel  = stat.sub_msb;
        ctrl.cntr_mux_sel = 1'b1;
      end
      imuldiv_ctrl_pkg::DONE: begin
        resp_val          = 1'b1;
        ctrl.rem_sign_sel = 1'b1;
        ctrl.div_sign_sel = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* verilog/imuldiv_issue_arbiter.sv */
/*
 * Steers each request to the divider or multiplier by function code and
 * round-robin arbitrates the two engines onto the shared response port.
 */
`timescale 1ns/100ps
`include "imuldiv_macros.svh"

module imuldiv_issue_arbiter (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  imuldiv_msg_pkg::req_msg_t  req_msg,
  output logic                       resp_val,
  output imuldiv_msg_pkg::resp_msg_t resp_msg,
  input  logic                       resp_rdy,
  output logic                       div_req_val,
  input  logic                       div_req_rdy,
  output logic                       mul_req_val,
  input  logic                       mul_req_rdy,
  input  logic                       div_resp_val,
  input  imuldiv_msg_pkg::resp_msg_t div_resp_msg,
  output logic                       div_resp_rdy,
  input  logic                       mul_resp_val,
  input  imuldiv_msg_pkg::resp_msg_t mul_resp_msg,
  output logic                       mul_resp_rdy
);

  logic is_div;
  logic is_mul;
  logic prio_mul;    // 1 = multiplier wins a tie
  logic hold_q;      // response offered last cycle and not taken
  logic hold_mul_q;  // which engine was offered
  logic grant_mul;

  //------------------------------------------------------------
  // request steering
  //------------------------------------------------------------

  assign is_div = (req_msg.fn == `IMULDIV_FN_DIV) || (req_msg.fn == `IMULDIV_FN_DIVU);
  assign is_mul = (req_msg.fn == `IMULDIV_FN_MUL);

  assign div_req_val = req_val && is_div;
  assign mul_req_val = req_val && is_mul;
  // unused code 3 is never accepted
  assign req_rdy = (is_div && div_req_rdy) || (is_mul && mul_req_rdy);

  //------------------------------------------------------------
  // response arbitration
  //------------------------------------------------------------

  // keep the offered engine while stalled so resp_msg stays stable
  assign grant_mul = hold_q ? hold_mul_q
                            : (mul_resp_val && (!div_resp_val || prio_mul));

  assign resp_val     = div_resp_val || mul_resp_val;
  assign resp_msg     = grant_mul ? mul_resp_msg : div_resp_msg;
  assign div_resp_rdy = resp_rdy && !grant_mul;
  assign mul_resp_rdy = resp_rdy && grant_mul;

  always_ff @(posedge clk) begin
    if (reset) begin
      prio_mul   <= 1'b0;
      hold_q     <= 1'b0;
      hold_mul_q <= 1'b0;
    end else begin
      hold_q     <= resp_val && !resp_rdy;
      hold_mul_q <= grant_mul;
      // pointer moves past the winner only on a completed transfer
      if (resp_val && resp_rdy) begin
        prio_mul <= !grant_mul;
      end
    end
  end

endmodule

/* verilog/imuldiv_macros.svh */
/*
 * Width, iteration and function-code constants for the multiply/divide unit.
 * Include wherever a package or module needs them.
 */
`ifndef IMULDIV_MACROS_SVH
`define IMULDIV_MACROS_SVH

//------------------------------------------------------------
// datapath sizing
//------------------------------------------------------------

// operand width, results are twice this
`define IMULDIV_XLEN 32

// one iteration per operand bit
`define IMULDIV_ITERS 32

// tag lets the consumer match out-of-order responses
`define IMULDIV_TAG_W 4

//------------------------------------------------------------
// function codes carried in req_msg.fn
//------------------------------------------------------------

`define IMULDIV_FN_W    2
`define IMULDIV_FN_MUL  2'd0
`define IMULDIV_FN_DIV  2'd1
`define IMULDIV_FN_DIVU 2'd2

`endif

/* verilog/imuldiv_msg_pkg.sv */
/*
 * Request and response messages at the boundary of the multiply/divide unit.
 * Referenced by scope from the top level, the arbiter and both engines.
 */
`include "imuldiv_macros.svh"

package imuldiv_msg_pkg;

  //------------------------------------------------------------
  // request, 70 bits
  //------------------------------------------------------------

  // fn selects the engine, tag comes back with the response
  typedef struct packed {
    logic [`IMULDIV_FN_W-1:0]  fn;
    logic [`IMULDIV_TAG_W-1:0] tag;
    logic [`IMULDIV_XLEN-1:0]  a;
    logic [`IMULDIV_XLEN-1:0]  b;
  } req_msg_t;

  //------------------------------------------------------------
  // response, 68 bits
  //------------------------------------------------------------

  // divides put remainder in the upper word and quotient in the lower
  // MUL returns the full 64-bit signed product
  typedef struct packed {
    logic [`IMULDIV_TAG_W-1:0]  tag;
    logic [2*`IMULDIV_XLEN-1:0] result;
  } resp_msg_t;

endpackage

/* verilog/imuldiv_mul_iterative.sv */
/*
 * Iterative shift-add multiplier for signed MUL, one multiplier bit per cycle.
 * Same IDLE/CALC/DONE handshake as the divider engine.
 */
`timescale 1ns/100ps
`include "imuldiv_macros.svh"

module imuldiv_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  input  imuldiv_msg_pkg::req_msg_t  req_msg,
  output logic                       req_rdy,
  output logic                       resp_val,
  output imuldiv_msg_pkg::resp_msg_t resp_msg,
  input  logic                       resp_rdy
);

  imuldiv_ctrl_pkg::mul_ctrl_t ctrl;
  imuldiv_ctrl_pkg::mul_stat_t stat;
  logic [2*`IMULDIV_XLEN-1:0]  result;
  logic [`IMULDIV_TAG_W-1:0]   tag_reg;

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      tag_reg <= req_msg.tag;
    end
  end

  assign resp_msg.tag    = tag_reg;
  assign resp_msg.result = result;

  imuldiv_mul_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .stat     (stat),
    .ctrl     (ctrl)
  );

  imuldiv_mul_dpath u_dpath (
    .clk     (clk),
    .reset   (reset),
    .req_msg (req_msg),
    .ctrl    (ctrl),
    .stat    (stat),
    .result  (result)
  );

endmodule

//------------------------------------------------------------
// datapath
//------------------------------------------------------------

module imuldiv_mul_dpath (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_msg_pkg::req_msg_t   req_msg,
  input  imuldiv_ctrl_pkg::mul_ctrl_t ctrl,
  output imuldiv_ctrl_pkg::mul_stat_t stat,
  output logic [2*`IMULDIV_XLEN-1:0]  result
);

  localparam int w = `IMULDIV_XLEN;

  logic [2*w-1:0]                       prod;
  logic [2*w-1:0]                       mcand;
  logic [w-1:0]                         mplier;
  logic [imuldiv_ctrl_pkg::cntr_w-1:0]  counter;
  logic                                 sign;

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      prod   <= '0;
      mcand  <= {{w{1'b0}}, req_msg.a[w-1] ? (~req_msg.a + 1'b1) : req_msg.a};
      mplier <= req_msg.b[w-1] ? (~req_msg.b + 1'b1) : req_msg.b;
      sign   <= req_msg.a[w-1] ^ req_msg.b[w-1];
    end else if (ctrl.shift) begin
      // multiplicand moves up as the multiplier drains out the bottom
      if (ctrl.add) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
    end else if (ctrl.load) begin
      counter <= imuldiv_ctrl_pkg::cntr_w'(`IMULDIV_ITERS - 1);
    end else if (ctrl.shift) begin
      counter <= counter - 1'b1;
    end
  end

  assign stat.mplier_lsb      = mplier[0];
  assign stat.counter_is_zero = (counter == '0);

  // product of magnitudes, negated when operand signs differ
  assign result = (ctrl.negate && sign) ? (~prod + 1'b1) : prod;

endmodule

//------------------------------------------------------------
// controller
//------------------------------------------------------------

module imuldiv_mul_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_val,
  output logic                        req_rdy,
  output logic                        resp_val,
  input  logic                        resp_rdy,
  input  imuldiv_ctrl_pkg::mul_stat_t stat,
  output imuldiv_ctrl_pkg::mul_ctrl_t ctrl
);

  imuldiv_ctrl_pkg::engine_state_t state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_ctrl_pkg::IDLE;
    end else begin
      case (state)
        imuldiv_ctrl_pkg::IDLE: if (req_val) state <= imuldiv_ctrl_pkg::CALC;
        imuldiv_ctrl_pkg::CALC: if (stat.counter_is_zero) state <= imuldiv_ctrl_pkg::DONE;
        imuldiv_ctrl_pkg::DONE: if (resp_rdy) state <= imuldiv_ctrl_pkg::IDLE;
        default: state <= imuldiv_ctrl_pkg::IDLE;
      endcase
    end
  end

  always_comb begin
    ctrl     = '0;
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    case (state)
      imuldiv_ctrl_pkg::IDLE: begin
        req_rdy   = 1'b1;
        ctrl.load = req_val;
      end
      imuldiv_ctrl_pkg::CALC: begin
        ctrl.shift = 1'b1;
        ctrl.add   = stat.mplier_lsb;
      end
      imuldiv_ctrl_pkg::DONE: begin
        resp_val    = 1'b1;
        ctrl.negate = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* verilog/imuldiv_top.sv */
/*
 * Iterative multiply/divide unit with one val/rdy request and response port.
 * Up to two operations in flight, one per engine, responses tagged.
 */
`timescale 1ns/100ps

module imuldiv_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  input  imuldiv_msg_pkg::req_msg_t  req_msg,
  output logic                       req_rdy,
  output logic                       resp_val,
  output imuldiv_msg_pkg::resp_msg_t resp_msg,
  input  logic                       resp_rdy
);

  // engine-side handshakes
  logic                       div_req_val;
  logic                       div_req_rdy;
  logic                       mul_req_val;
  logic                       mul_req_rdy;
  logic                       div_resp_val;
  logic                       div_resp_rdy;
  logic                       mul_resp_val;
  logic                       mul_resp_rdy;
  imuldiv_msg_pkg::resp_msg_t div_resp_msg;
  imuldiv_msg_pkg::resp_msg_t mul_resp_msg;

  imuldiv_issue_arbiter u_arb (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .req_msg      (req_msg),
    .resp_val     (resp_val),
    .resp_msg     (resp_msg),
    .resp_rdy     (resp_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_resp_val (div_resp_val),
    .div_resp_msg (div_resp_msg),
    .div_resp_rdy (div_resp_rdy),
    .mul_resp_val (mul_resp_val),
    .mul_resp_msg (mul_resp_msg),
    .mul_resp_rdy (mul_resp_rdy)
  );

  // both engines see the full request, only one sees req_val
  imuldiv_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_msg  (req_msg),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_msg (div_resp_msg),
    .resp_rdy (div_resp_rdy)
  );

  imuldiv_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_msg  (req_msg),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_msg (mul_resp_msg),
    .resp_rdy (mul_resp_rdy)
  );

endmodule
